//--- rtl/spi_pkg.sv
// spi byte type, command field types and constants, command decoder state enum
`default_nettype none

package spi_pkg;

    typedef logic [7:0] spi_byte_t;     // one byte as clocked over spi
    typedef logic [2:0] cmd_len_t;      // command length field in bits 7..5

    // ==================================================
    // command byte layout
    // ==================================================
    localparam int CMD_LEN_LSB = 5;     // length occupies bits 7..5
    localparam int CMD_A16_BIT = 0;     // address bit 16 rides in the command byte

    localparam cmd_len_t CMD_LEN_NEXT  = 3'd1;  // read-next, command only
    localparam cmd_len_t CMD_LEN_READ  = 3'd3;  // command, addr hi, addr lo
    localparam cmd_len_t CMD_LEN_WRITE = 3'd4;  // command, data, addr hi, addr lo

    // decoder states, in the order the arguments arrive
    typedef enum logic [2:0] {
        READ_CMD,
        READ_DATA_ARG,
        READ_ADDR_HI_ARG,
        READ_ADDR_LO_ARG,
        XFER,
        DONE
    } com_state_t;

endpackage

`default_nettype wire

//--- rtl/bus_pkg.sv
// memory bus address and data types
`default_nettype none

package bus_pkg;

    // ==================================================
    // byte-wide memory bus
    // ==================================================
    localparam int BUS_ADDR_W = 17;     // 128 KiB host address space
    localparam int BUS_DATA_W = 8;

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;

    // a target decodes only the low bits it needs, the rest alias

endpackage

`default_nettype wire

//--- rtl/spi_byte.sv
// spi mode 0 byte receiver with pin synchronizers and tri-state transmit shifter
`timescale 1ns/1ps
`default_nettype none

module spi_byte import spi_pkg::*; (
    input  logic      sys_clk,
    input  logic      reset,
    input  logic      spi_sclk,
    input  logic      spi_cs_n,
    input  logic      spi_rx,
    input  spi_byte_t tx_byte,
    inout  wire       spi_tx,
    output spi_byte_t rx_byte,
    output logic      rx_valid,
    output logic      cs_active
);

    logic [1:0] sclk_sync;
    logic [1:0] cs_sync;
    logic [1:0] rx_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;        // bits received in the current byte
    logic       byte_full;      // eighth bit has just been shifted in
    spi_byte_t  rx_shift;
    spi_byte_t  tx_shift;

    // ==================================================
    // pin synchronizers and sclk edge detect
    // ==================================================
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            sclk_sync <= 2'b00;
            cs_sync   <= 2'b11;     // deselected until the pins say otherwise
            rx_sync   <= 2'b00;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_sclk};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            rx_sync   <= {rx_sync[0], spi_rx};
            sclk_prev <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_prev;
    assign sclk_fall = ~sclk_sync[1] & sclk_prev;
    assign cs_active = ~cs_sync[1];

    // ==================================================
    // receive path
    // ==================================================
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            bit_cnt   <= 3'd0;
            byte_full <= 1'b0;
            rx_valid  <= 1'b0;
        end else begin
            byte_full <= 1'b0;
            rx_valid  <= byte_full;         // second stage after the eighth edge
            if (!cs_active) begin
                bit_cnt <= 3'd0;            // a new session always starts on a byte boundary
            end else if (sclk_rise) begin
                bit_cnt   <= bit_cnt + 3'd1;
                byte_full <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[6:0], rx_sync[1]};    // msb first
        end
        if (byte_full) begin
            rx_byte <= rx_shift;
        end
    end

    // ==================================================
    // transmit path
    // ==================================================
    // Between bytes the shifter keeps loading tx_byte, which covers the cs rise
    // and the rx_valid cycle and also picks up read data that lands later
    always_ff @(posedge sys_clk) begin
        if (bit_cnt == 3'd0) begin
            tx_shift <= tx_byte;
        end else if (sclk_fall) begin
            tx_shift <= {tx_shift[6:0], 1'b0};  // next bit ready before the next rising edge
        end
    end

    assign spi_tx = cs_active ? tx_shift[7] : 1'bz;    // released while deselected

endmodule

`default_nettype wire

//--- rtl/pi_com.sv
// command decoder fsm that collects spi arguments and holds one bus request
`timescale 1ns/1ps
`default_nettype none

module pi_com import spi_pkg::*, bus_pkg::*; (
    input  logic      sys_clk,
    input  logic      reset,
    input  logic      rx_valid,
    input  logic      cs_active,
    input  spi_byte_t rx_byte,
    input  logic      done_in,
    output bus_addr_t addr,
    output bus_data_t wdata,
    output logic      rw_b,
    output logic      pending,
    output logic      done
);

    com_state_t state;
    cmd_len_t   cmd_len;
    logic       cmd_a16;

    // fields of the command byte, only meaningful in READ_CMD
    assign cmd_len = rx_byte[CMD_LEN_LSB +: 3];
    assign cmd_a16 = rx_byte[CMD_A16_BIT];

    // ==================================================
    // decoder fsm
    // ==================================================
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            state   <= READ_CMD;
            addr    <= '0;
            rw_b    <= 1'b1;
            pending <= 1'b0;
            done    <= 1'b0;
        end else if (!cs_active) begin
            // session over, addr is kept so read-next carries on
            state   <= READ_CMD;
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            case (state)
                READ_CMD: begin
                    if (rx_valid) begin
                        case (cmd_len)
                            CMD_LEN_NEXT: begin
                                addr  <= addr + bus_addr_t'(1);   // wraps at 17 bits
                                rw_b  <= 1'b1;
                                state <= XFER;
                            end
                            CMD_LEN_READ: begin
                                addr[16] <= cmd_a16;
                                rw_b     <= 1'b1;
                                state    <= READ_ADDR_HI_ARG;
                            end
                            CMD_LEN_WRITE: begin
                                addr[16] <= cmd_a16;
                                rw_b     <= 1'b0;
                                state    <= READ_DATA_ARG;
                            end
                            default: begin
                                state <= READ_CMD;  // unknown length, byte dropped
                            end
                        endcase
                    end
                end

                READ_DATA_ARG: begin
                    if (rx_valid) begin
                        state <= READ_ADDR_HI_ARG;  // data itself lands in wdata below
                    end
                end

                READ_ADDR_HI_ARG: begin
                    if (rx_valid) begin
                        addr[15:8] <= rx_byte;
                        state      <= READ_ADDR_LO_ARG;
                    end
                end

                READ_ADDR_LO_ARG: begin
                    if (rx_valid) begin
                        addr[7:0] <= rx_byte;
                        state     <= XFER;
                    end
                end

                XFER: begin
                    if (done_in) begin
                        pending <= 1'b0;
                        done    <= 1'b1;
                        state   <= DONE;
                    end else begin
                        pending <= 1'b1;    // held until the memory answers
                    end
                end

                DONE: begin
                    state <= DONE;          // extra bytes are ignored until cs rises
                end

                default: begin
                    state <= READ_CMD;
                end
            endcase
        end
    end

    // write data argument
    always_ff @(posedge sys_clk) begin
        if (cs_active && rx_valid && state == READ_DATA_ARG) begin
            wdata <= rx_byte;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_target.sv
// wait-state byte memory that serves one pending request and pulses done
`timescale 1ns/1ps
`default_nettype none

module mem_target import bus_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10,
    parameter int WAIT_CYCLES   = 2
) (
    input  logic      sys_clk,
    input  logic      reset,
    input  logic      pending,
    input  logic      rw_b,
    input  bus_addr_t addr,
    input  bus_data_t wdata,
    output bus_data_t rdata,
    output logic      done_in
);

    localparam int MEM_DEPTH = 1 << MEM_ADDR_BITS;
    localparam int CNT_W     = $clog2(WAIT_CYCLES + 2);

    bus_data_t                mem [MEM_DEPTH];
    logic [MEM_ADDR_BITS-1:0] mem_addr;
    logic                     pending_prev;
    logic                     busy;
    logic                     start;
    logic                     fire;
    logic [CNT_W-1:0]         wait_cnt;
    logic [CNT_W-1:0]         cur_cnt;

    assign mem_addr = addr[MEM_ADDR_BITS-1:0];     // upper address bits alias

    // ==================================================
    // request timing
    // ==================================================
    assign start   = pending & ~pending_prev & ~busy;  // only on a fresh rising edge
    assign cur_cnt = busy ? wait_cnt : '0;
    assign fire    = pending & (start | busy) & (cur_cnt == CNT_W'(WAIT_CYCLES));

    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            pending_prev <= 1'b0;
            busy         <= 1'b0;
            wait_cnt     <= '0;
            done_in      <= 1'b0;
        end else begin
            pending_prev <= pending;
            done_in      <= fire;
            if (fire || !pending) begin
                busy     <= 1'b0;       // a dropped request is abandoned
                wait_cnt <= '0;
            end else if (start || busy) begin
                busy     <= 1'b1;
                wait_cnt <= cur_cnt + 1'b1;
            end
        end
    end

    // storage, the access takes effect in the same cycle done_in rises
    always_ff @(posedge sys_clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (fire) begin
            if (rw_b) begin
                rdata <= mem[mem_addr];         // held until the next read
            end else begin
                mem[mem_addr] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/pet_spi_top.sv
// top level tying the spi byte receiver, command decoder and memory target together
`timescale 1ns/1ps
`default_nettype none

module pet_spi_top import spi_pkg::*, bus_pkg::*; #(
    parameter int MEM_ADDR_BITS = 10,
    parameter int WAIT_CYCLES   = 2
) (
    input  logic sys_clk,
    input  logic reset,
    input  logic spi_sclk,
    input  logic spi_cs_n,
    input  logic spi_rx,
    inout  wire  spi_tx,
    output logic done
);

    spi_byte_t rx_byte;
    logic      rx_valid;
    logic      cs_active;
    bus_addr_t addr;
    bus_data_t wdata;
    bus_data_t rdata;
    logic      rw_b;
    logic      pending;
    logic      done_in;

    // ==================================================
    // spi side
    // ==================================================
    spi_byte u_spi_byte (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .spi_sclk  (spi_sclk),
        .spi_cs_n  (spi_cs_n),
        .spi_rx    (spi_rx),
        .tx_byte   (rdata),         // read data goes straight back to the host
        .spi_tx    (spi_tx),
        .rx_byte   (rx_byte),
        .rx_valid  (rx_valid),
        .cs_active (cs_active)
    );

    pi_com u_pi_com (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .rx_valid  (rx_valid),
        .cs_active (cs_active),
        .rx_byte   (rx_byte),
        .done_in   (done_in),
        .addr      (addr),
        .wdata     (wdata),
        .rw_b      (rw_b),
        .pending   (pending),
        .done      (done)
    );

    // ==================================================
    // memory side
    // ==================================================
    mem_target #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS),
        .WAIT_CYCLES   (WAIT_CYCLES)
    ) u_mem_target (
        .sys_clk (sys_clk),
        .reset   (reset),
        .pending (pending),
        .rw_b    (rw_b),
        .addr    (addr),
        .wdata   (wdata),
        .rdata   (rdata),
        .done_in (done_in)
    );

endmodule

`default_nettype wire

//--- tests/pet_spi_props.sv
// concurrent assertions on the command decoder state and its memory handshake
`timescale 1ns/1ps
`default_nettype none

module pet_spi_props import spi_pkg::*; (
    input logic       sys_clk,
    input logic       reset,
    input logic       cs_active,
    input com_state_t state,
    input logic       pending,
    input logic       done_in
);

    int assert_failures = 0;    // read by the testbench at the end of the run

    // ==================================================
    // request handshake
    // ==================================================
    // a live request only drops once the memory has answered
    a_pending_held: assert property (@(posedge sys_clk) disable iff (reset)
        pending && !done_in && cs_active |=> pending)
        else begin assert_failures++; $error("pending dropped before done_in"); end

    a_done_pulse: assert property (@(posedge sys_clk) disable iff (reset)
        done_in |=> !done_in)
        else begin assert_failures++; $error("done_in lasted more than one cycle"); end

    a_done_needs_pending: assert property (@(posedge sys_clk) disable iff (reset)
        done_in |-> pending)
        else begin assert_failures++; $error("done_in without a pending request"); end

    // the synchronous clear lands one cycle after cs_active falls
    a_idle_deselected: assert property (@(posedge sys_clk) disable iff (reset)
        !cs_active |=> state == READ_CMD)
        else begin assert_failures++; $error("decoder not idle while deselected"); end

endmodule

`default_nettype wire

//--- tests/tb_pet_spi.sv
// testbench for the spi memory bridge with spi host tasks, directed tests and a watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_pet_spi import spi_pkg::*, bus_pkg::*; ();

    localparam int CLK_PERIOD    = 10;
    localparam int MEM_ADDR_BITS = 10;
    localparam int WAIT_CYCLES   = 2;
    localparam int MEM_DEPTH     = 1 << MEM_ADDR_BITS;
    localparam int SPI_DIV       = 8;      // sys_clk cycles per sclk period
    localparam int DONE_TIMEOUT  = 64;     // in cycles and well above WAIT_CYCLES+6
    localparam int NUM_SESSIONS  = 24;
    localparam int WATCHDOG_NS   = NUM_SESSIONS * 40 * SPI_DIV * CLK_PERIOD + 16 * CLK_PERIOD;

    logic sys_clk;
    logic reset;
    logic spi_sclk;
    logic spi_cs_n;
    logic spi_rx;
    logic done;
    wire  spi_tx;

    bus_data_t   model [MEM_DEPTH];        // expected memory contents
    int          error_count;
    int          check_count;
    logic [31:0] lfsr_state = 32'h8b4d_a7f7;

    pulldown pd_tx (spi_tx);               // a released spi_tx reads low

    pet_spi_top #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS),
        .WAIT_CYCLES   (WAIT_CYCLES)
    ) UUT (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .spi_sclk (spi_sclk),
        .spi_cs_n (spi_cs_n),
        .spi_rx   (spi_rx),
        .spi_tx   (spi_tx),
        .done     (done)
    );

    bind pi_com pet_spi_props u_props (
        .sys_clk   (sys_clk),
        .reset     (reset),
        .cs_active (cs_active),
        .state     (state),
        .pending   (pending),
        .done_in   (done_in)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // ==================================================
    // helpers
    // ==================================================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;   // taps 32, 22, 2, 1
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // the memory decodes only the low address bits
    function automatic int model_index(input bus_addr_t a);
        return int'(a[MEM_ADDR_BITS-1:0]);
    endfunction

    function automatic spi_byte_t cmd_byte(input cmd_len_t len, input logic a16);
        return {len, 4'b0000, a16};
    endfunction

    task automatic check_data(input string sig, input bus_data_t exp, input bus_data_t act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected 8'h%02h actual 8'h%02h", $time, sig, exp, act);
        end
    endtask

    task automatic check_bit(input string sig, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s expected %b actual %b", $time, sig, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        if (error_count == start_errors) begin
            $display("test %s: passed", name);
        end else begin
            $display("test %s: failed with %0d errors", name, error_count - start_errors);
        end
    endtask

    // ==================================================
    // spi host
    // ==================================================
    // mode 0 host sending msb first and sampling tx just before each rising sclk edge
    task automatic spi_exchange(input spi_byte_t tx, output spi_byte_t rx);
        spi_byte_t got;
        for (int i = 7; i >= 0; i--) begin
            @(posedge sys_clk);
            spi_sclk <= 1'b0;
            spi_rx   <= tx[i];
            repeat (SPI_DIV / 2 - 1) @(posedge sys_clk);
            @(negedge sys_clk);
            got[i] = spi_tx;
            @(posedge sys_clk);
            spi_sclk <= 1'b1;
            repeat (SPI_DIV / 2 - 1) @(posedge sys_clk);
        end
        @(posedge sys_clk);
        spi_sclk <= 1'b0;
        rx = got;
    endtask

    task automatic start_session();
        @(posedge sys_clk);
        spi_cs_n <= 1'b0;
        repeat (4) @(posedge sys_clk);      // let cs pass the synchronizer
    endtask

    task automatic end_session();
        @(posedge sys_clk);
        spi_cs_n <= 1'b1;
        repeat (8) @(posedge sys_clk);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge sys_clk);
        while (done !== 1'b1 && n < DONE_TIMEOUT) begin
            @(negedge sys_clk);
            n++;
        end
        if (done !== 1'b1) begin
            error_count++;
            $display("done did not rise within %0d cycles, at %0t", DONE_TIMEOUT, $time);
        end
    endtask

    task automatic write_cmd(input bus_addr_t a, input bus_data_t d);
        spi_byte_t dummy;
        start_session();
        spi_exchange(cmd_byte(CMD_LEN_WRITE, a[16]), dummy);
        spi_exchange(d, dummy);
        spi_exchange(a[15:8], dummy);
        spi_exchange(a[7:0], dummy);
        wait_done();
        end_session();
        model[model_index(a)] = d;
    endtask

    task automatic read_cmd(input bus_addr_t a, output bus_data_t d);
        spi_byte_t dummy;
        start_session();
        spi_exchange(cmd_byte(CMD_LEN_READ, a[16]), dummy);
        spi_exchange(a[15:8], dummy);
        spi_exchange(a[7:0], dummy);
        wait_done();
        spi_exchange(8'h00, d);             // read data comes back on this byte
        end_session();
    endtask

    task automatic read_next_cmd(output bus_data_t d);
        spi_byte_t dummy;
        start_session();
        spi_exchange(cmd_byte(CMD_LEN_NEXT, 1'b0), dummy);
        wait_done();
        spi_exchange(8'h00, d);
        end_session();
    endtask

    // ==================================================
    // directed tests
    // ==================================================
    task automatic test_after_reset();
        int        start_errors;
        bus_addr_t a;
        bus_data_t got;
        start_errors = error_count;
        @(negedge sys_clk);
        check_bit("done", 1'b0, done);
        check_bit("spi_tx", 1'b0, spi_tx);
        a = bus_addr_t'(take_bits(17));
        read_cmd(a, got);
        check_data("read data after reset", 8'h00, got);
        report_test("after_reset", start_errors);
    endtask

    task automatic test_write_read();
        int        start_errors;
        bus_addr_t addrs [3];
        bus_data_t got;
        start_errors = error_count;
        for (int i = 0; i < 3; i++) begin
            addrs[i] = bus_addr_t'(take_bits(17));
            write_cmd(addrs[i], bus_data_t'(take_bits(8)));
        end
        for (int i = 0; i < 3; i++) begin
            read_cmd(addrs[i], got);
            check_data("read data", model[model_index(addrs[i])], got);
        end
        report_test("write_read", start_errors);
    endtask

    task automatic test_read_next();
        int          start_errors;
        logic [31:0] r;
        bus_addr_t   base;
        bus_addr_t   next_addr;
        bus_data_t   got;
        start_errors = error_count;
        r    = take_bits(9);
        base = {r[8:0], 8'hfe};             // base+2 carries into the high byte
        for (int k = 0; k < 4; k++) begin
            write_cmd(bus_addr_t'(base + k), bus_data_t'(take_bits(8)));
        end
        read_cmd(base, got);
        check_data("read data", model[model_index(base)], got);
        next_addr = base;
        for (int k = 1; k < 4; k++) begin
            next_addr = bus_addr_t'(next_addr + 1);
            read_next_cmd(got);
            check_data("read-next data", model[model_index(next_addr)], got);
        end
        report_test("read_next", start_errors);
    endtask

    task automatic test_addr16_alias();
        int          start_errors;
        logic [31:0] r;
        bus_addr_t   wr_addr;
        bus_addr_t   rd_addr;
        bus_data_t   data;
        bus_data_t   got;
        start_errors = error_count;
        r       = take_bits(16);
        wr_addr = {1'b1, r[15:0]};
        rd_addr = {1'b0, ~r[15:10], r[9:0]};   // same low bits with other upper bits
        data    = bus_data_t'(take_bits(8));
        write_cmd(wr_addr, data);
        read_cmd(rd_addr, got);
        check_data("aliased read data", data, got);
        read_cmd(wr_addr, got);
        check_data("bit 16 read data", data, got);
        report_test("addr16_alias", start_errors);
    endtask

    task automatic test_aborted_session();
        int        start_errors;
        bus_addr_t a;
        bus_data_t old;
        bus_data_t data;
        bus_data_t got;
        spi_byte_t dummy;
        start_errors = error_count;
        a   = bus_addr_t'(take_bits(17));
        old = model[model_index(a)];
        read_cmd(a, got);                   // a stray write from the aborted command lands here
        check_data("memory before abort", old, got);
        start_session();
        spi_exchange(cmd_byte(CMD_LEN_WRITE, a[16]), dummy);
        spi_exchange(~old, dummy);
        repeat (2 * SPI_DIV) @(posedge sys_clk);
        @(negedge sys_clk);
        check_bit("done during aborted write", 1'b0, done);
        end_session();
        @(negedge sys_clk);
        check_bit("done after aborted write", 1'b0, done);
        read_cmd(a, got);
        check_data("memory after abort", old, got);
        data = bus_data_t'(take_bits(8));
        write_cmd(a, data);
        read_cmd(a, got);
        check_data("read data after abort", data, got);
        report_test("aborted_session", start_errors);
    endtask

    task automatic test_done_level();
        int        start_errors;
        bus_addr_t a;
        bus_data_t data;
        spi_byte_t dummy;
        start_errors = error_count;
        a    = bus_addr_t'(take_bits(17));
        data = bus_data_t'(take_bits(8));
        start_session();
        spi_exchange(cmd_byte(CMD_LEN_WRITE, a[16]), dummy);
        spi_exchange(data, dummy);
        spi_exchange(a[15:8], dummy);
        spi_exchange(a[7:0], dummy);
        wait_done();
        model[model_index(a)] = data;
        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        check_bit("done before cs rise", 1'b1, done);
        @(posedge sys_clk);
        spi_cs_n <= 1'b1;
        repeat (3) @(posedge sys_clk);      // two synchronizer stages and then the clear
        @(negedge sys_clk);
        check_bit("done after cs rise", 1'b0, done);
        check_bit("spi_tx after cs rise", 1'b0, spi_tx);
        repeat (8) @(posedge sys_clk);
        report_test("done_level", start_errors);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        reset       = 1'b1;
        spi_sclk    = 1'b0;
        spi_cs_n    = 1'b1;
        spi_rx      = 1'b0;
        error_count = 0;
        check_count = 0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (16) @(posedge sys_clk);
        reset <= 1'b0;
        repeat (4) @(posedge sys_clk);

        test_after_reset();
        test_write_read();
        test_read_next();
        test_addr16_alias();
        test_aborted_session();
        test_done_level();

        if (UUT.u_pi_com.u_props.assert_failures != 0) begin
            $display("%0d assertion failures", UUT.u_pi_com.u_props.assert_failures);
            error_count += UUT.u_pi_com.u_props.assert_failures;
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
rtl/spi_pkg.sv
rtl/bus_pkg.sv
rtl/spi_byte.sv
rtl/pi_com.sv
rtl/mem_target.sv
rtl/pet_spi_top.sv
tests/pet_spi_props.sv
tests/tb_pet_spi.sv

//--- Bender.yml
package:
  name: pet_spi

sources:
  # packages first, then the design bottom-up
  - files:
      - rtl/spi_pkg.sv
      - rtl/bus_pkg.sv
      - rtl/spi_byte.sv
      - rtl/pi_com.sv
      - rtl/mem_target.sv
      - rtl/pet_spi_top.sv

  # simulation only
  - target: test
    files:
      - tests/pet_spi_props.sv
      - tests/tb_pet_spi.sv

# top modules: pet_spi_top for the design, tb_pet_spi for simulation
